//--- src/vwrite_pkg.sv
package vwrite_pkg;

   localparam int BUS_ADDR_W = 32;
   localparam int BUS_DATA_W = 32;
   localparam int LEN_W      = 16;

   typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
   typedef logic [BUS_DATA_W-1:0] bus_data_t;
   typedef logic [LEN_W-1:0]      len_t;
   typedef logic [4:0]            cfg_idx_t;

   // databus transfer settings
   localparam cfg_idx_t REG_EXT_ADDR   = 5'd0;
   localparam cfg_idx_t REG_ADDR_SHIFT = 5'd1;
   localparam cfg_idx_t REG_LENGTH     = 5'd2;
   localparam cfg_idx_t REG_AMOUNT     = 5'd3;
   localparam cfg_idx_t REG_ENABLE     = 5'd4;
   // read side generator
   localparam cfg_idx_t REG_W_START    = 5'd5;
   localparam cfg_idx_t REG_W_INCR     = 5'd6;
   localparam cfg_idx_t REG_W_PER      = 5'd7;
   localparam cfg_idx_t REG_W_DUTY     = 5'd8;
   localparam cfg_idx_t REG_W_ITER     = 5'd9;
   localparam cfg_idx_t REG_W_SHIFT    = 5'd10;
   // store side generator
   localparam cfg_idx_t REG_S_START    = 5'd11;
   localparam cfg_idx_t REG_S_INCR     = 5'd12;
   localparam cfg_idx_t REG_S_PER      = 5'd13;
   localparam cfg_idx_t REG_S_DUTY     = 5'd14;
   localparam cfg_idx_t REG_S_ITER     = 5'd15;
   localparam cfg_idx_t REG_S_SHIFT    = 5'd16;
   localparam cfg_idx_t REG_DELAY      = 5'd17;
   localparam cfg_idx_t REG_PINGPONG   = 5'd18;

   typedef enum logic [1:0] {
      IDLE,
      REQUEST,
      BEATS,
      FINISH
   } writer_state_e;

endpackage

//--- src/vwrite_config.sv
`timescale 1ns/1ns

module vwrite_config import vwrite_pkg::*; #(
   parameter int ADDR_W   = 6,
   parameter int PERIOD_W = 4,
   parameter int DELAY_W  = 7
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                cfg_we_i,
   input  cfg_idx_t            cfg_idx_i,
   input  bus_data_t           cfg_wdata_i,
   output bus_addr_t           ext_addr_o,
   output bus_addr_t           addr_shift_o,
   output len_t                length_o,
   output len_t                amount_o,
   output logic                enable_o,
   output logic                pingpong_o,
   output logic [DELAY_W-1:0]  delay_o,
   output logic [ADDR_W-1:0]   w_start_o, w_incr_o, w_iter_o, w_shift_o,
   output logic [PERIOD_W-1:0] w_per_o, w_duty_o,
   output logic [ADDR_W-1:0]   s_start_o, s_incr_o, s_iter_o, s_shift_o,
   output logic [PERIOD_W-1:0] s_per_o, s_duty_o
);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ext_addr_o   <= '0;
         addr_shift_o <= '0;
         length_o     <= '0;
         amount_o     <= '0;
         enable_o     <= 1'b0;
         pingpong_o   <= 1'b0;
         delay_o      <= '0;
         w_start_o    <= '0;
         w_incr_o     <= '0;
         w_per_o      <= '0;
         w_duty_o     <= '0;
         w_iter_o     <= '0;
         w_shift_o    <= '0;
         s_start_o    <= '0;
         s_incr_o     <= '0;
         s_per_o      <= '0;
         s_duty_o     <= '0;
         s_iter_o     <= '0;
         s_shift_o    <= '0;
      end else if (cfg_we_i) begin
         // each register keeps its low bits only
         case (cfg_idx_i)
            REG_EXT_ADDR:   ext_addr_o   <= cfg_wdata_i;
            REG_ADDR_SHIFT: addr_shift_o <= cfg_wdata_i;
            REG_LENGTH:     length_o     <= cfg_wdata_i[LEN_W-1:0];
            REG_AMOUNT:     amount_o     <= cfg_wdata_i[LEN_W-1:0];
            REG_ENABLE:     enable_o     <= cfg_wdata_i[0];
            REG_W_START:    w_start_o    <= cfg_wdata_i[ADDR_W-1:0];
            REG_W_INCR:     w_incr_o     <= cfg_wdata_i[ADDR_W-1:0];
            REG_W_PER:      w_per_o      <= cfg_wdata_i[PERIOD_W-1:0];
            REG_W_DUTY:     w_duty_o     <= cfg_wdata_i[PERIOD_W-1:0];
            REG_W_ITER:     w_iter_o     <= cfg_wdata_i[ADDR_W-1:0];
            REG_W_SHIFT:    w_shift_o    <= cfg_wdata_i[ADDR_W-1:0];
            REG_S_START:    s_start_o    <= cfg_wdata_i[ADDR_W-1:0];
            REG_S_INCR:     s_incr_o     <= cfg_wdata_i[ADDR_W-1:0];
            REG_S_PER:      s_per_o      <= cfg_wdata_i[PERIOD_W-1:0];
            REG_S_DUTY:     s_duty_o     <= cfg_wdata_i[PERIOD_W-1:0];
            REG_S_ITER:     s_iter_o     <= cfg_wdata_i[ADDR_W-1:0];
            REG_S_SHIFT:    s_shift_o    <= cfg_wdata_i[ADDR_W-1:0];
            REG_DELAY:      delay_o      <= cfg_wdata_i[DELAY_W-1:0];
            REG_PINGPONG:   pingpong_o   <= cfg_wdata_i[0];
            default: ;
         endcase
      end
   end

   a_known_index: assert property (@(posedge clk) disable iff (rst)
      cfg_we_i |-> cfg_idx_i <= REG_PINGPONG);

endmodule

//--- src/addr_gen.sv
`timescale 1ns/1ns

module addr_gen #(
   parameter int ADDR_W   = 6,
   parameter int PERIOD_W = 4,
   parameter int DELAY_W  = 7
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                run_i,
   input  logic [DELAY_W-1:0]  delay_i,
   input  logic [ADDR_W-1:0]   start_i,
   input  logic [ADDR_W-1:0]   incr_i,
   input  logic [PERIOD_W-1:0] per_i,
   input  logic [PERIOD_W-1:0] duty_i,
   input  logic [ADDR_W-1:0]   iter_i,
   input  logic [ADDR_W-1:0]   shift_i,
   input  logic                ready_i,
   output logic                valid_o,
   output logic [ADDR_W-1:0]   addr_o,
   output logic                done_o
);

   // settings taken at run
   logic [ADDR_W-1:0]   incr_q;
   logic [ADDR_W-1:0]   shift_q;
   logic [PERIOD_W-1:0] per_q;
   logic [PERIOD_W-1:0] duty_q;
   logic [ADDR_W-1:0]   iter_q;
   logic [ADDR_W-1:0]   base_q;

   logic [DELAY_W-1:0]  delay_cnt;
   logic [PERIOD_W-1:0] p_cnt;
   logic [ADDR_W-1:0]   i_cnt;
   logic                busy;
   logic                active;
   logic                step;
   logic                last_p;
   logic                last_out;

   assign active  = busy && (delay_cnt == '0);
   assign valid_o = active && (p_cnt < duty_q);
   // idle part of a period never waits for ready
   assign step    = active && (ready_i || !valid_o);
   assign last_p  = (p_cnt == per_q - 1'b1);
   // walk ends at the last accepted address of the last iteration
   assign last_out = (i_cnt == iter_q - 1'b1) &&
                     (last_p || (valid_o && p_cnt == duty_q - 1'b1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         done_o    <= 1'b1;
         delay_cnt <= '0;
         p_cnt     <= '0;
         i_cnt     <= '0;
      end else if (run_i) begin
         busy      <= (iter_i != '0);
         done_o    <= (iter_i == '0);
         delay_cnt <= delay_i;
         p_cnt     <= '0;
         i_cnt     <= '0;
      end else if (busy && delay_cnt != '0) begin
         delay_cnt <= delay_cnt - 1'b1;
      end else if (step) begin
         if (last_out) begin
            busy   <= 1'b0;
            done_o <= 1'b1;
         end else if (last_p) begin
            p_cnt <= '0;
            i_cnt <= i_cnt + 1'b1;
         end else begin
            p_cnt <= p_cnt + 1'b1;
         end
      end
   end

   // address arithmetic wraps at the buffer size
   always_ff @(posedge clk) begin
      if (run_i) begin
         incr_q  <= incr_i;
         shift_q <= shift_i;
         per_q   <= per_i;
         duty_q  <= duty_i;
         iter_q  <= iter_i;
         base_q  <= start_i;
         addr_o  <= start_i;
      end else if (step) begin
         if (last_p) begin
            base_q <= base_q + shift_q;
            addr_o <= base_q + shift_q;
         end else begin
            addr_o <= addr_o + incr_q;
         end
      end
   end

   a_addr_hold: assert property (@(posedge clk) disable iff (rst)
      valid_o && !ready_i && !run_i |=> $stable(addr_o));

endmodule

//--- src/memory_reader.sv
`timescale 1ns/1ns

module memory_reader import vwrite_pkg::*; #(
   parameter int ADDR_W = 6
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              s_valid_i,
   output logic              s_ready_o,
   input  logic [ADDR_W-1:0] s_addr_i,
   output logic              m_valid_o,
   input  logic              m_ready_i,
   output bus_data_t         m_data_o,
   output logic              mem_read_o,
   output logic [ADDR_W-1:0] mem_addr_o,
   input  bus_data_t         mem_data_i
);

   // pend marks a read issued last cycle whose word sits on mem_data_i
   logic      pend;
   logic      hold_valid;
   bus_data_t hold_data;
   logic      fire;

   // holding register is always the older word
   assign m_valid_o  = hold_valid || pend;
   assign m_data_o   = hold_valid ? hold_data : mem_data_i;
   assign fire       = m_valid_o && m_ready_i;
   assign s_ready_o  = !(hold_valid && pend) || m_ready_i;
   assign mem_read_o = s_valid_i && s_ready_o;
   assign mem_addr_o = s_addr_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pend       <= 1'b0;
         hold_valid <= 1'b0;
      end else begin
         // a stalled word stays in the buffer output when no new read goes out
         pend       <= mem_read_o || (pend && hold_valid && !fire);
         hold_valid <= hold_valid ? (pend || !fire) : (pend && !fire);
      end
   end

   always_ff @(posedge clk) begin
      if (pend && (hold_valid == fire)) begin
         hold_data <= mem_data_i;
      end
   end

   a_data_hold: assert property (@(posedge clk) disable iff (rst)
      m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o));

endmodule

//--- src/databus_writer.sv
`timescale 1ns/1ns

module databus_writer import vwrite_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run_i,
   input  logic                    enable_i,
   input  bus_addr_t               ext_addr_i,
   input  bus_addr_t               addr_shift_i,
   input  len_t                    length_i,
   input  len_t                    amount_i,
   input  logic                    data_valid_i,
   input  bus_data_t               data_i,
   output logic                    data_ready_o,
   input  logic                    databus_ready_i,
   input  logic                    databus_last_i,
   output logic                    databus_valid_o,
   output bus_addr_t               databus_addr_o,
   output len_t                    databus_len_o,
   output bus_data_t               databus_wdata_o,
   output logic [BUS_DATA_W/8-1:0] databus_wstrb_o,
   output logic                    done_o
);

   writer_state_e  state;
   bus_addr_t      shift_q;
   len_t           length_q;
   len_t           beat_cnt;
   // one extra bit since the count is amount plus one
   logic [LEN_W:0] left;
   logic           beat;
   logic           burst_end;

   assign databus_valid_o = (state == BEATS) && data_valid_i;
   assign data_ready_o    = (state == BEATS) && databus_ready_i;
   assign databus_wdata_o = data_i;
   assign databus_wstrb_o = '1;
   assign beat            = databus_valid_o && databus_ready_i;
   assign burst_end       = (beat_cnt == databus_len_o - 1'b1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state          <= IDLE;
         done_o         <= 1'b1;
         left           <= '0;
         beat_cnt       <= '0;
         shift_q        <= '0;
         length_q       <= '0;
         databus_addr_o <= '0;
         databus_len_o  <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (run_i && enable_i) begin
                  state          <= REQUEST;
                  done_o         <= 1'b0;
                  left           <= amount_i + 1'b1;
                  shift_q        <= addr_shift_i;
                  length_q       <= length_i;
                  databus_addr_o <= ext_addr_i;
               end
            end
            REQUEST: begin
               // last burst takes whatever remains
               databus_len_o <= (left < length_q) ? left[LEN_W-1:0] : length_q;
               beat_cnt      <= '0;
               state         <= BEATS;
            end
            BEATS: begin
               if (beat) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  left     <= left - 1'b1;
                  if (burst_end) begin
                     databus_addr_o <= databus_addr_o + shift_q;
                     state          <= (left == 1) ? FINISH : REQUEST;
                  end
               end
            end
            FINISH: begin
               done_o <= 1'b1;
               state  <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   a_last_at_end: assert property (@(posedge clk) disable iff (rst)
      beat && databus_last_i |-> burst_end);

endmodule

//--- src/buffer_2p.sv
`timescale 1ns/1ns

module buffer_2p import vwrite_pkg::*; #(
   parameter int ADDR_W = 6
) (
   input  logic              clk,
   input  logic              write_i,
   input  logic [ADDR_W-1:0] waddr_i,
   input  bus_data_t         wdata_i,
   input  logic              read_i,
   input  logic [ADDR_W-1:0] raddr_i,
   output bus_data_t         rdata_o
);

   bus_data_t mem [2**ADDR_W];

   // read returns the old word on a same-address write
   always_ff @(posedge clk) begin
      if (write_i) begin
         mem[waddr_i] <= wdata_i;
      end
      if (read_i) begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

//--- src/vwrite_unit.sv
`timescale 1ns/1ns

module vwrite_unit import vwrite_pkg::*; #(
   parameter int ADDR_W   = 6,
   parameter int PERIOD_W = 4,
   parameter int DELAY_W  = 7
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run_i,
   output logic                    done_o,
   input  bus_data_t               in_data_i,
   input  logic                    databus_ready_i,
   input  logic                    databus_last_i,
   output logic                    databus_valid_o,
   output bus_addr_t               databus_addr_o,
   output len_t                    databus_len_o,
   output bus_data_t               databus_wdata_o,
   output logic [BUS_DATA_W/8-1:0] databus_wstrb_o,
   output logic                    buf_write_o,
   output logic [ADDR_W-1:0]       buf_waddr_o,
   output bus_data_t               buf_wdata_o,
   output logic                    buf_read_o,
   output logic [ADDR_W-1:0]       buf_raddr_o,
   input  bus_data_t               buf_rdata_i,
   input  bus_addr_t               ext_addr_i,
   input  bus_addr_t               addr_shift_i,
   input  len_t                    length_i,
   input  len_t                    amount_i,
   input  logic                    enable_i,
   input  logic                    pingpong_i,
   input  logic [DELAY_W-1:0]      delay_i,
   input  logic [ADDR_W-1:0]       w_start_i, w_incr_i, w_iter_i, w_shift_i,
   input  logic [PERIOD_W-1:0]     w_per_i, w_duty_i,
   input  logic [ADDR_W-1:0]       s_start_i, s_incr_i, s_iter_i, s_shift_i,
   input  logic [PERIOD_W-1:0]     s_per_i, s_duty_i
);

   logic              pp_state;
   logic [ADDR_W-1:0] s_addr;
   logic              s_done;
   logic              w_valid;
   logic              w_ready;
   logic [ADDR_W-1:0] w_addr;
   logic [ADDR_W-1:0] w_addr_pp;
   logic              rd_valid;
   logic              rd_ready;
   bus_data_t         rd_data;
   logic              xfer_done;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
         done_o   <= 1'b1;
      end else begin
         if (run_i) begin
            pp_state <= pingpong_i ? !pp_state : 1'b0;
         end
         if (run_i) begin
            done_o <= 1'b0;
         end else if (s_done && xfer_done) begin
            done_o <= 1'b1;
         end
      end
   end

   // store into one half, send the other
   assign buf_waddr_o = pingpong_i ? {pp_state, s_addr[ADDR_W-2:0]} : s_addr;
   assign w_addr_pp   = pingpong_i ? {!pp_state, w_addr[ADDR_W-2:0]} : w_addr;
   assign buf_wdata_o = in_data_i;

   addr_gen #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .DELAY_W (DELAY_W)
   ) u_store_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i),
      .delay_i(delay_i),
      .start_i(s_start_i),
      .incr_i (s_incr_i),
      .per_i  (s_per_i),
      .duty_i (s_duty_i),
      .iter_i (s_iter_i),
      .shift_i(s_shift_i),
      .ready_i(1'b1),
      .valid_o(buf_write_o),
      .addr_o (s_addr),
      .done_o (s_done)
   );

   // read side only runs when the transfer is enabled
   addr_gen #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .DELAY_W (DELAY_W)
   ) u_read_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i && enable_i),
      .delay_i('0),
      .start_i(w_start_i),
      .incr_i (w_incr_i),
      .per_i  (w_per_i),
      .duty_i (w_duty_i),
      .iter_i (w_iter_i),
      .shift_i(w_shift_i),
      .ready_i(w_ready),
      .valid_o(w_valid),
      .addr_o (w_addr),
      .done_o ()
   );

   memory_reader #(
      .ADDR_W(ADDR_W)
   ) u_reader (
      .clk       (clk),
      .rst       (rst),
      .s_valid_i (w_valid),
      .s_ready_o (w_ready),
      .s_addr_i  (w_addr_pp),
      .m_valid_o (rd_valid),
      .m_ready_i (rd_ready),
      .m_data_o  (rd_data),
      .mem_read_o(buf_read_o),
      .mem_addr_o(buf_raddr_o),
      .mem_data_i(buf_rdata_i)
   );

   databus_writer u_writer (
      .clk            (clk),
      .rst            (rst),
      .run_i          (run_i),
      .enable_i       (enable_i),
      .ext_addr_i     (ext_addr_i),
      .addr_shift_i   (addr_shift_i),
      .length_i       (length_i),
      .amount_i       (amount_i),
      .data_valid_i   (rd_valid),
      .data_i         (rd_data),
      .data_ready_o   (rd_ready),
      .databus_ready_i(databus_ready_i),
      .databus_last_i (databus_last_i),
      .databus_valid_o(databus_valid_o),
      .databus_addr_o (databus_addr_o),
      .databus_len_o  (databus_len_o),
      .databus_wdata_o(databus_wdata_o),
      .databus_wstrb_o(databus_wstrb_o),
      .done_o         (xfer_done)
   );

   // in ping-pong mode the generators must stay inside one half
   a_store_half: assert property (@(posedge clk) disable iff (rst)
      pingpong_i && buf_write_o |-> !s_addr[ADDR_W-1]);
   a_read_half: assert property (@(posedge clk) disable iff (rst)
      pingpong_i && w_valid |-> !w_addr[ADDR_W-1]);

endmodule

//--- src/vwrite_top.sv
`timescale 1ns/1ns

module vwrite_top import vwrite_pkg::*; #(
   parameter int ADDR_W   = 6,
   parameter int PERIOD_W = 4,
   parameter int DELAY_W  = 7
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    cfg_we_i,
   input  cfg_idx_t                cfg_idx_i,
   input  bus_data_t               cfg_wdata_i,
   input  logic                    run_i,
   output logic                    done_o,
   input  bus_data_t               in_data_i,
   input  logic                    databus_ready_i,
   input  logic                    databus_last_i,
   output logic                    databus_valid_o,
   output bus_addr_t               databus_addr_o,
   output len_t                    databus_len_o,
   output bus_data_t               databus_wdata_o,
   output logic [BUS_DATA_W/8-1:0] databus_wstrb_o
);

   bus_addr_t           ext_addr, addr_shift;
   len_t                length, amount;
   logic                enable, pingpong;
   logic [DELAY_W-1:0]  delay;
   logic [ADDR_W-1:0]   w_start, w_incr, w_iter, w_shift;
   logic [ADDR_W-1:0]   s_start, s_incr, s_iter, s_shift;
   logic [PERIOD_W-1:0] w_per, w_duty, s_per, s_duty;
   logic                buf_write;
   logic                buf_read;
   logic [ADDR_W-1:0]   buf_waddr;
   logic [ADDR_W-1:0]   buf_raddr;
   bus_data_t           buf_wdata;
   bus_data_t           buf_rdata;

   vwrite_config #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .DELAY_W (DELAY_W)
   ) u_config (
      .clk         (clk),
      .rst         (rst),
      .cfg_we_i    (cfg_we_i),
      .cfg_idx_i   (cfg_idx_i),
      .cfg_wdata_i (cfg_wdata_i),
      .ext_addr_o  (ext_addr),
      .addr_shift_o(addr_shift),
      .length_o    (length),
      .amount_o    (amount),
      .enable_o    (enable),
      .pingpong_o  (pingpong),
      .delay_o     (delay),
      .w_start_o   (w_start),
      .w_incr_o    (w_incr),
      .w_per_o     (w_per),
      .w_duty_o    (w_duty),
      .w_iter_o    (w_iter),
      .w_shift_o   (w_shift),
      .s_start_o   (s_start),
      .s_incr_o    (s_incr),
      .s_per_o     (s_per),
      .s_duty_o    (s_duty),
      .s_iter_o    (s_iter),
      .s_shift_o   (s_shift)
   );

   vwrite_unit #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .DELAY_W (DELAY_W)
   ) u_unit (
      .clk            (clk),
      .rst            (rst),
      .run_i          (run_i),
      .done_o         (done_o),
      .in_data_i      (in_data_i),
      .databus_ready_i(databus_ready_i),
      .databus_last_i (databus_last_i),
      .databus_valid_o(databus_valid_o),
      .databus_addr_o (databus_addr_o),
      .databus_len_o  (databus_len_o),
      .databus_wdata_o(databus_wdata_o),
      .databus_wstrb_o(databus_wstrb_o),
      .buf_write_o    (buf_write),
      .buf_waddr_o    (buf_waddr),
      .buf_wdata_o    (buf_wdata),
      .buf_read_o     (buf_read),
      .buf_raddr_o    (buf_raddr),
      .buf_rdata_i    (buf_rdata),
      .ext_addr_i     (ext_addr),
      .addr_shift_i   (addr_shift),
      .length_i       (length),
      .amount_i       (amount),
      .enable_i       (enable),
      .pingpong_i     (pingpong),
      .delay_i        (delay),
      .w_start_i      (w_start),
      .w_incr_i       (w_incr),
      .w_iter_i       (w_iter),
      .w_shift_i      (w_shift),
      .w_per_i        (w_per),
      .w_duty_i       (w_duty),
      .s_start_i      (s_start),
      .s_incr_i       (s_incr),
      .s_iter_i       (s_iter),
      .s_shift_i      (s_shift),
      .s_per_i        (s_per),
      .s_duty_i       (s_duty)
   );

   buffer_2p #(
      .ADDR_W(ADDR_W)
   ) u_buffer (
      .clk    (clk),
      .write_i(buf_write),
      .waddr_i(buf_waddr),
      .wdata_i(buf_wdata),
      .read_i (buf_read),
      .raddr_i(buf_raddr),
      .rdata_o(buf_rdata)
   );

endmodule

//--- tests/vwrite_tb.sv
`timescale 1ns/1ns

module vwrite_tb import vwrite_pkg::*; ();

   localparam int ADDR_W   = 6;
   localparam int PERIOD_W = 4;
   localparam int DELAY_W  = 7;
   localparam int DEPTH    = 2**ADDR_W;
   localparam int HIST     = 4096;

   logic                    clk;
   logic                    rst;
   logic                    cfg_we_i;
   cfg_idx_t                cfg_idx_i;
   bus_data_t               cfg_wdata_i;
   logic                    run_i;
   logic                    done_o;
   bus_data_t               in_data_i = '0;
   logic                    databus_ready_i = 1'b0;
   logic                    databus_last_i = 1'b0;
   logic                    databus_valid_o;
   bus_addr_t               databus_addr_o;
   len_t                    databus_len_o;
   bus_data_t               databus_wdata_o;
   logic [BUS_DATA_W/8-1:0] databus_wstrb_o;

   // each process keeps its own LCG state seeded with 77
   logic [31:0] set_state = 32'd77;
   logic [31:0] stream_state = 32'd77;
   logic [31:0] ready_state = 32'd77;

   // buffer model and expected databus traffic
   bus_data_t model [DEPTH];
   bus_data_t stream_hist [HIST];
   bus_data_t word_q [$];
   len_t      burst_len_q [$];
   bus_addr_t burst_addr_q [$];
   int        beat_in_burst = 0;
   int        cycle = 0;
   int        cycle_limit = 1000;

   // current settings
   int        s_start, s_incr, s_per, s_duty, s_iter, s_shift;
   int        w_start, w_incr, w_per, w_duty, w_iter, w_shift;
   int        delay;
   int        length;
   bus_addr_t ext_addr;
   bus_addr_t addr_shift;
   logic      enable;
   logic      pingpong;
   logic      pp_half;
   logic      bp_on;

   vwrite_top #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .DELAY_W (DELAY_W)
   ) u_dut (
      .clk            (clk),
      .rst            (rst),
      .cfg_we_i       (cfg_we_i),
      .cfg_idx_i      (cfg_idx_i),
      .cfg_wdata_i    (cfg_wdata_i),
      .run_i          (run_i),
      .done_o         (done_o),
      .in_data_i      (in_data_i),
      .databus_ready_i(databus_ready_i),
      .databus_last_i (databus_last_i),
      .databus_valid_o(databus_valid_o),
      .databus_addr_o (databus_addr_o),
      .databus_len_o  (databus_len_o),
      .databus_wdata_o(databus_wdata_o),
      .databus_wstrb_o(databus_wstrb_o)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int rand_below(input int n);
      set_state = lcg_next(set_state);
      return int'(set_state[30:16]) % n;
   endfunction

   function automatic logic [ADDR_W-1:0] addr_at(input int start, input int incr,
                                                 input int shift, input int i, input int p);
      return ADDR_W'((start + i * shift + p * incr) % DEPTH);
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input bus_data_t got, input bus_data_t exp, input string what);
      if (got !== exp) begin
         report_failure($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_addr(input bus_addr_t got, input bus_addr_t exp, input string what);
      if (got !== exp) begin
         report_failure($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_len(input len_t got, input len_t exp, input string what);
      if (got !== exp) begin
         report_failure($sformatf("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
      end
   endtask

   task automatic check_done(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         report_failure($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   // stream source, cycle count and timeout
   always @(posedge clk) begin
      stream_state = lcg_next(stream_state);
      in_data_i <= stream_state;
      stream_hist[cycle % HIST] <= stream_state;
      cycle <= cycle + 1;
      if (cycle > cycle_limit) begin
         report_failure($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
      end
   end

   // databus slave raises last with ready on the final beat of a burst
   always @(posedge clk) begin
      logic r;
      ready_state = lcg_next(ready_state);
      r = !bp_on || ready_state[28];
      databus_ready_i <= r;
      databus_last_i  <= r && (burst_len_q.size() != 0) &&
                         (beat_in_burst == burst_len_q[0] - 1);
   end

   // a beat seen here is taken at the next rising edge
   always @(negedge clk) begin
      if (!rst && databus_valid_o && databus_ready_i) begin
         if (word_q.size() == 0 || burst_len_q.size() == 0) begin
            report_failure($sformatf("databus beat at %0t ns that was never expected", $time));
         end else begin
            check_addr(databus_addr_o, burst_addr_q[0], "burst address");
            check_len(databus_len_o, burst_len_q[0], "burst length");
            check_word(databus_wdata_o, word_q.pop_front(), "beat data");
            check_word(bus_data_t'(databus_wstrb_o), 32'hf, "write strobe");
            beat_in_burst = beat_in_burst + 1;
            if (beat_in_burst == burst_len_q[0]) begin
               beat_in_burst = 0;
               burst_len_q.delete(0);
               burst_addr_q.delete(0);
            end
         end
      end
   end

   task automatic write_cfg(input cfg_idx_t idx, input bus_data_t value);
      @(posedge clk);
      cfg_we_i    <= 1'b1;
      cfg_idx_i   <= idx;
      cfg_wdata_i <= value;
   endtask

   task automatic pick_pattern();
      s_start = rand_below(4);
      s_incr  = rand_below(3);
      s_per   = 1 + rand_below(4);
      s_duty  = 1 + rand_below(s_per);
      s_iter  = 1 + rand_below(7);
      s_shift = rand_below(4);
      delay   = rand_below(20);
   endtask

   task automatic mirror_pattern();
      w_start = s_start;
      w_incr  = s_incr;
      w_per   = s_per;
      w_duty  = s_duty;
      w_iter  = s_iter;
      w_shift = s_shift;
   endtask

   task automatic run_once();
      int                count;
      int                rem;
      int                k;
      int                i;
      int                p;
      int                c0;
      logic [ADDR_W-1:0] a;
      count = enable ? w_iter * w_duty : 0;
      write_cfg(REG_EXT_ADDR, ext_addr);
      write_cfg(REG_ADDR_SHIFT, addr_shift);
      write_cfg(REG_LENGTH, bus_data_t'(length));
      write_cfg(REG_AMOUNT, bus_data_t'(enable ? count - 1 : 0));
      write_cfg(REG_ENABLE, bus_data_t'(enable));
      write_cfg(REG_W_START, bus_data_t'(w_start));
      write_cfg(REG_W_INCR, bus_data_t'(w_incr));
      write_cfg(REG_W_PER, bus_data_t'(w_per));
      write_cfg(REG_W_DUTY, bus_data_t'(w_duty));
      write_cfg(REG_W_ITER, bus_data_t'(w_iter));
      write_cfg(REG_W_SHIFT, bus_data_t'(w_shift));
      write_cfg(REG_S_START, bus_data_t'(s_start));
      write_cfg(REG_S_INCR, bus_data_t'(s_incr));
      write_cfg(REG_S_PER, bus_data_t'(s_per));
      write_cfg(REG_S_DUTY, bus_data_t'(s_duty));
      write_cfg(REG_S_ITER, bus_data_t'(s_iter));
      write_cfg(REG_S_SHIFT, bus_data_t'(s_shift));
      write_cfg(REG_DELAY, bus_data_t'(delay));
      write_cfg(REG_PINGPONG, bus_data_t'(pingpong));
      @(posedge clk);
      cfg_we_i <= 1'b0;
      @(negedge clk);
      // half that this run stores into
      pp_half = pingpong ? !pp_half : 1'b0;
      if (enable) begin
         for (i = 0; i < w_iter; i++) begin
            for (p = 0; p < w_duty; p++) begin
               a = addr_at(w_start, w_incr, w_shift, i, p);
               if (pingpong) begin
                  a[ADDR_W-1] = !pp_half;
               end
               word_q.push_back(model[a]);
            end
         end
         rem = count;
         k = 0;
         while (rem > 0) begin
            burst_len_q.push_back(len_t'(rem < length ? rem : length));
            burst_addr_q.push_back(ext_addr + bus_addr_t'(k) * addr_shift);
            rem = rem - length;
            k = k + 1;
         end
      end
      cycle_limit = cycle_limit + 4 * (s_iter * s_per + (enable ? w_iter * w_per : 0) + delay);
      @(posedge clk);
      run_i <= 1'b1;
      c0 = cycle + 1;
      @(posedge clk);
      run_i <= 1'b0;
      @(negedge clk);
      check_done(done_o, 1'b0, "done after run");
      while (!done_o) begin
         @(negedge clk);
      end
      if (word_q.size() != 0 || burst_len_q.size() != 0) begin
         report_failure("done rose while databus beats were still missing");
      end
      // word taken in the cycle of step n lands at edge c0+delay+n+1
      for (i = 0; i < s_iter; i++) begin
         for (p = 0; p < s_duty; p++) begin
            a = addr_at(s_start, s_incr, s_shift, i, p);
            if (pingpong) begin
               a[ADDR_W-1] = pp_half;
            end
            model[a] = stream_hist[(c0 + delay + i * s_per + p) % HIST];
         end
      end
   endtask

   initial begin
      rst         = 1'b1;
      cfg_we_i    = 1'b0;
      cfg_idx_i   = '0;
      cfg_wdata_i = '0;
      run_i       = 1'b0;
      pp_half     = 1'b0;
      bp_on       = 1'b0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_done(done_o, 1'b1, "done after reset");
      check_done(databus_valid_o, 1'b0, "databus valid after reset");

      // store only with duty below period and a nonzero shift
      s_start = 3;
      s_incr = 2;
      s_per = 5;
      s_duty = 3;
      s_iter = 4;
      s_shift = 9;
      delay = 5;
      mirror_pattern();
      pingpong = 1'b0;
      enable = 1'b0;
      length = 5;
      ext_addr = 32'h0000_1000;
      addr_shift = 32'h40;
      run_once();
      // transfer only with 12 words in bursts of 5, 5 and 2
      s_iter = 0;
      enable = 1'b1;
      run_once();

      // random patterns under back-pressure
      bp_on = 1'b1;
      repeat (3) begin
         pick_pattern();
         mirror_pattern();
         enable = 1'b0;
         run_once();
         s_iter = 0;
         enable = 1'b1;
         length = 1 + rand_below(6);
         ext_addr = bus_addr_t'(rand_below(4096)) << 4;
         addr_shift = bus_addr_t'(1 + rand_below(64)) << 2;
         run_once();
      end

      // in ping-pong mode the first run only fills a half
      pick_pattern();
      mirror_pattern();
      pingpong = 1'b1;
      enable = 1'b0;
      run_once();
      enable = 1'b1;
      repeat (3) begin
         delay = rand_below(20);
         length = 1 + rand_below(6);
         run_once();
      end

      $display("Simulation passed");
      $finish;
   end

endmodule

//--- vwrite_top.f
src/vwrite_pkg.sv
src/vwrite_config.sv
src/addr_gen.sv
src/memory_reader.sv
src/databus_writer.sv
src/buffer_2p.sv
src/vwrite_unit.sv
src/vwrite_top.sv
tests/vwrite_tb.sv

//--- Bender.yml
package:
  name: vwrite

sources:
  - src/vwrite_pkg.sv
  - src/vwrite_config.sv
  - src/addr_gen.sv
  - src/memory_reader.sv
  - src/databus_writer.sv
  - src/buffer_2p.sv
  - src/vwrite_unit.sv
  - src/vwrite_top.sv
  - target: test
    files:
      - tests/vwrite_tb.sv
